// File: src/icache_defs.svh
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// ==================================================
// cache geometry
// ==================================================

// index bits, giving 2**IC_N sets of one word each.
`define IC_N 4

// byte offset bits inside a 32-bit word.
`define IC_M 2

// fetches from addresses below this limit go straight to memory.
`define UNCACHED_LIMIT 32'h1000_0000

// ==================================================
// performance counters
// ==================================================

`define COUNT_W 16

`endif

// File: src/icache_pkg.sv
`include "icache_defs.svh"

package icache_pkg;

  // one cache line holds a single instruction word.
  typedef struct packed {
    logic                    valid;
    logic [31-`IC_N-`IC_M:0] tag;
    logic [31:0]             inst;
  } icache_entry_t;

  // IDLE waits for a fetch, CHECK compares the tag, EXEC waits on memory,
  // HOLD presents the word until the fetch unit takes it.
  typedef enum logic [1:0] {
    IDLE,
    CHECK,
    EXEC,
    HOLD
  } icache_state_t;

endpackage

// File: src/icache_array.sv
`timescale 1ns/10ps
`include "icache_defs.svh"

module icache_array
  import icache_pkg::*;
(
  input  logic             clock,
  input  logic             reset,
  input  logic [`IC_N-1:0] index,
  output icache_entry_t    rd_entry,
  input  logic             we,
  input  icache_entry_t    wr_entry
);

  localparam int SETS = 1 << `IC_N;

  logic [SETS-1:0] valid_q;
  icache_entry_t   entry_mem [SETS];

  // valid bits live apart from the storage so reset can wipe them in one cycle.
  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
    end else if (we) begin
      valid_q[index] <= wr_entry.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (we) begin
      entry_mem[index] <= wr_entry;
    end
  end

  // the stored valid field is ignored, the register copy wins.
  always_comb begin
    rd_entry       = entry_mem[index];
    rd_entry.valid = valid_q[index];
  end

endmodule

// File: src/icache_ctrl.sv
`timescale 1ns/10ps
`include "icache_defs.svh"

module icache_ctrl
  import icache_pkg::*;
(
  input  logic             clock,
  input  logic             reset,

  input  logic             ifu_arvalid,
  input  logic [31:0]      ifu_araddr,
  output logic             ifu_arready,
  output logic             ifu_rvalid,
  output logic [31:0]      ifu_rdata,
  input  logic             ifu_rready,

  output logic             mem_arvalid,
  output logic [31:0]      mem_araddr,
  input  logic             mem_arready,
  input  logic             mem_rvalid,
  output logic             mem_rready,
  input  logic [31:0]      mem_rdata,

  output logic [`IC_N-1:0] ic_index,
  input  icache_entry_t    ic_rdata,
  output logic             ic_we,
  output icache_entry_t    ic_wdata,

  output logic             hit_evt,
  output logic             miss_evt,
  output logic             bypass_evt
);

  icache_state_t state, state_next;

  logic [31:0] addr_q;
  logic        accept;
  logic        bypass_req;
  logic        cached;
  logic        hit;
  logic        ar_done;
  logic        r_done;

  assign ifu_arready = (state == IDLE);
  assign accept      = ifu_arvalid && ifu_arready;
  assign bypass_req  = (ifu_araddr < `UNCACHED_LIMIT);

  // everything after acceptance works from the latched address.
  assign cached     = (addr_q >= `UNCACHED_LIMIT);
  assign ic_index   = addr_q[`IC_M+`IC_N-1:`IC_M];
  assign hit        = ic_rdata.valid && (ic_rdata.tag == addr_q[31:`IC_M+`IC_N]);
  assign mem_araddr = addr_q;

  assign ar_done = mem_arvalid && mem_arready;
  assign r_done  = mem_rvalid && mem_rready;

  // ==================================================
  // state machine
  // ==================================================

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    unique case (state)
      IDLE: begin
        if (accept) begin
          state_next = bypass_req ? EXEC : CHECK;
        end
      end
      CHECK: state_next = hit ? HOLD : EXEC;
      EXEC: begin
        if (r_done) begin
          state_next = HOLD;
        end
      end
      HOLD: begin
        if (ifu_rready) begin
          state_next = IDLE;
        end
      end
    endcase
  end

  // ==================================================
  // handshake and event outputs
  // ==================================================

  always_ff @(posedge clock) begin
    if (reset) begin
      ifu_rvalid  <= 1'b0;
      mem_arvalid <= 1'b0;
      mem_rready  <= 1'b0;
      ic_we       <= 1'b0;
      hit_evt     <= 1'b0;
      miss_evt    <= 1'b0;
      bypass_evt  <= 1'b0;
    end else begin
      ic_we      <= 1'b0;
      hit_evt    <= 1'b0;
      miss_evt   <= 1'b0;
      bypass_evt <= 1'b0;
      unique case (state)
        IDLE: begin
          if (accept && bypass_req) begin
            mem_arvalid <= 1'b1;
            bypass_evt  <= 1'b1;
          end
        end
        CHECK: begin
          if (hit) begin
            ifu_rvalid <= 1'b1;
            hit_evt    <= 1'b1;
          end else begin
            mem_arvalid <= 1'b1;
            miss_evt    <= 1'b1;
          end
        end
        EXEC: begin
          if (ar_done) begin
            mem_arvalid <= 1'b0;
            mem_rready  <= 1'b1;
          end
          if (r_done) begin
            mem_rready <= 1'b0;
            ifu_rvalid <= 1'b1;
            ic_we      <= cached;
          end
        end
        HOLD: begin
          if (ifu_rready) begin
            ifu_rvalid <= 1'b0;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      addr_q <= ifu_araddr;
    end
    if (state == CHECK && hit) begin
      ifu_rdata <= ic_rdata.inst;
    end
    if (state == EXEC && r_done) begin
      ifu_rdata <= mem_rdata;
      ic_wdata  <= '{valid: 1'b1, tag: addr_q[31:`IC_M+`IC_N], inst: mem_rdata};
    end
  end

endmodule

// File: src/icache_perf.sv
`timescale 1ns/10ps
`include "icache_defs.svh"

module icache_perf (
  input  logic                clock,
  input  logic                reset,
  input  logic                hit_evt,
  input  logic                miss_evt,
  input  logic                bypass_evt,
  output logic [`COUNT_W-1:0] hit_count,
  output logic [`COUNT_W-1:0] miss_count,
  output logic [`COUNT_W-1:0] bypass_count
);

  logic [2:0]          evt;
  logic [`COUNT_W-1:0] count [3];

  // slot 0 counts hits, slot 1 misses, slot 2 bypasses.
  assign evt = {bypass_evt, miss_evt, hit_evt};

  for (genvar i = 0; i < 3; i++) begin : g_count
    // a full counter holds its value rather than wrapping to zero.
    always_ff @(posedge clock) begin
      if (reset) begin
        count[i] <= '0;
      end else if (evt[i] && (count[i] != '1)) begin
        count[i] <= count[i] + 1'b1;
      end
    end
  end

  assign hit_count    = count[0];
  assign miss_count   = count[1];
  assign bypass_count = count[2];

endmodule

// File: src/icache_top.sv
`timescale 1ns/10ps
`include "icache_defs.svh"

module icache_top
  import icache_pkg::*;
(
  input  logic                clock,
  input  logic                reset,

  input  logic                ifu_arvalid,
  input  logic [31:0]         ifu_araddr,
  output logic                ifu_arready,
  output logic                ifu_rvalid,
  output logic [31:0]         ifu_rdata,
  input  logic                ifu_rready,

  output logic                mem_arvalid,
  output logic [31:0]         mem_araddr,
  input  logic                mem_arready,
  input  logic                mem_rvalid,
  output logic                mem_rready,
  input  logic [31:0]         mem_rdata,

  output logic [`COUNT_W-1:0] hit_count,
  output logic [`COUNT_W-1:0] miss_count,
  output logic [`COUNT_W-1:0] bypass_count
);

  logic [`IC_N-1:0] ic_index;
  icache_entry_t    ic_rdata;
  logic             ic_we;
  icache_entry_t    ic_wdata;
  logic             hit_evt;
  logic             miss_evt;
  logic             bypass_evt;

  icache_ctrl i_ctrl (
    .clock       (clock),
    .reset       (reset),
    .ifu_arvalid (ifu_arvalid),
    .ifu_araddr  (ifu_araddr),
    .ifu_arready (ifu_arready),
    .ifu_rvalid  (ifu_rvalid),
    .ifu_rdata   (ifu_rdata),
    .ifu_rready  (ifu_rready),
    .mem_arvalid (mem_arvalid),
    .mem_araddr  (mem_araddr),
    .mem_arready (mem_arready),
    .mem_rvalid  (mem_rvalid),
    .mem_rready  (mem_rready),
    .mem_rdata   (mem_rdata),
    .ic_index    (ic_index),
    .ic_rdata    (ic_rdata),
    .ic_we       (ic_we),
    .ic_wdata    (ic_wdata),
    .hit_evt     (hit_evt),
    .miss_evt    (miss_evt),
    .bypass_evt  (bypass_evt)
  );

  icache_array i_array (
    .clock    (clock),
    .reset    (reset),
    .index    (ic_index),
    .rd_entry (ic_rdata),
    .we       (ic_we),
    .wr_entry (ic_wdata)
  );

  icache_perf i_perf (
    .clock        (clock),
    .reset        (reset),
    .hit_evt      (hit_evt),
    .miss_evt     (miss_evt),
    .bypass_evt   (bypass_evt),
    .hit_count    (hit_count),
    .miss_count   (miss_count),
    .bypass_count (bypass_count)
  );

endmodule

// File: tests/icache_props.sv
`timescale 1ns/10ps
`include "icache_defs.svh"

module icache_props
  import icache_pkg::*;
(
  input logic          clock,
  input logic          reset,
  input logic          ifu_rvalid,
  input logic          ifu_rready,
  input logic [31:0]   ifu_rdata,
  input logic          mem_arvalid,
  input logic          mem_arready,
  input logic [31:0]   mem_araddr,
  input logic          mem_rvalid,
  input logic          mem_rready,
  input logic          ic_we,
  input icache_state_t state
);

  rvalid_stable: assert property (@(posedge clock) disable iff (reset)
    ifu_rvalid && !ifu_rready |=> ifu_rvalid && $stable(ifu_rdata))
    else $error("fetch response dropped or changed before it was taken");

  arvalid_stable: assert property (@(posedge clock) disable iff (reset)
    mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_araddr))
    else $error("memory read request dropped or changed before it was taken");

  // the fill write lands one cycle after the memory word arrives.
  fill_source: assert property (@(posedge clock) disable iff (reset)
    ic_we |-> $past(mem_rvalid && mem_rready) && (mem_araddr >= `UNCACHED_LIMIT))
    else $error("array written without a cached memory transfer");

  rvalid_in_hold: assert property (@(posedge clock) disable iff (reset)
    ifu_rvalid |-> state == HOLD)
    else $error("fetch response valid outside HOLD");

endmodule

bind icache_ctrl icache_props i_props (
  .clock       (clock),
  .reset       (reset),
  .ifu_rvalid  (ifu_rvalid),
  .ifu_rready  (ifu_rready),
  .ifu_rdata   (ifu_rdata),
  .mem_arvalid (mem_arvalid),
  .mem_arready (mem_arready),
  .mem_araddr  (mem_araddr),
  .mem_rvalid  (mem_rvalid),
  .mem_rready  (mem_rready),
  .ic_we       (ic_we),
  .state       (state)
);

// File: tests/icache_tb.sv
`timescale 1ns/10ps
`include "icache_defs.svh"

module icache_tb;

  localparam int NUM_REQ   = 400;
  localparam int RESET_CYC = 16;
  localparam int CYC_LIMIT = NUM_REQ * 40 + RESET_CYC;
  localparam int SETS      = 1 << `IC_N;
  localparam int OFS       = `IC_N + `IC_M;

  logic                clock = 1'b0;
  logic                reset;
  logic                ifu_arvalid, ifu_arready, ifu_rvalid, ifu_rready;
  logic [31:0]         ifu_araddr, ifu_rdata;
  logic                mem_arvalid, mem_arready, mem_rvalid, mem_rready;
  logic [31:0]         mem_araddr, mem_rdata, mem_seen_addr;
  logic [`COUNT_W-1:0] hit_count, miss_count, bypass_count;

  integer      seed = 32'h3a614030;
  int          errors = 0;
  int          cycles = 0;
  int          ar_delay, r_delay, mem_reads;
  int          n_hit, n_miss, n_bypass;
  logic [31:0] tb_mem [8*SETS];
  logic        m_valid [SETS];
  logic [31:0] m_addr [SETS];
  logic [31:0] m_data [SETS];

  icache_top i_dut (.*);

  always #10 clock = ~clock;

  always @(posedge clock) begin
    cycles++;
    if (cycles > CYC_LIMIT) begin
      $display("timeout: run still busy after %0d cycles, %0d errors", CYC_LIMIT, errors);
      $display("Done: errors found");
      $finish;
    end
  end

  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  // ==================================================
  // address pool
  // ==================================================

  // slots 0 and 1 lie below the uncached limit.
  function automatic logic [31:0] slot_base(input int slot);
    case (slot)
      0: return 32'h0000_0400;
      1: return 32'h0fff_ffc0;
      2: return 32'h1000_0000;
      3: return 32'h1000_0040;
      4: return 32'h2345_6780;
      5: return 32'h4000_1000;
      6: return 32'h8000_0000;
      default: return 32'hffff_ffc0;
    endcase
  endfunction

  function automatic int mem_key(input logic [31:0] addr);
    for (int s = 0; s < 8; s++) begin
      if ((slot_base(s) >> OFS) == (addr >> OFS)) return s * SETS + addr[OFS-1:`IC_M];
    end
    return 0;
  endfunction

  // ==================================================
  // memory responder
  // ==================================================

  initial begin
    mem_arready   = 1'b0;
    mem_rvalid    = 1'b0;
    mem_rdata     = '0;
    mem_seen_addr = '0;
    forever begin
      next_cycle();
      if (mem_arvalid === 1'b1) begin
        repeat (ar_delay) next_cycle();
        mem_arready   = 1'b1;
        mem_seen_addr = mem_araddr;
        next_cycle();
        mem_arready = 1'b0;
        mem_reads++;
        repeat (r_delay) next_cycle();
        mem_rvalid = 1'b1;
        mem_rdata  = tb_mem[mem_key(mem_seen_addr)];
        while (!mem_rready) next_cycle();
        next_cycle();
        mem_rvalid = 1'b0;
      end
    end
  end

  task automatic run_request(input logic [31:0] addr);
    int          set;
    int          reads0;
    int          edges;
    int          stall;
    logic        cached;
    logic        hit;
    logic        first;
    logic [31:0] expected;
    set      = addr[OFS-1:`IC_M];
    cached   = addr >= `UNCACHED_LIMIT;
    first    = cached && !m_valid[set];
    hit      = cached && m_valid[set] && (m_addr[set] >> OFS) == (addr >> OFS);
    expected = hit ? m_data[set] : tb_mem[mem_key(addr)];
    if (!cached) begin
      n_bypass++;
    end else if (hit) begin
      n_hit++;
    end else begin
      n_miss++;
      m_valid[set] = 1'b1;
      m_addr[set]  = addr;
      m_data[set]  = expected;
    end
    ar_delay = $unsigned($random(seed)) % 4;
    r_delay  = $unsigned($random(seed)) % 4;
    stall    = $unsigned($random(seed)) % 4;
    reads0   = mem_reads;
    ifu_arvalid = 1'b1;
    ifu_araddr  = addr;
    while (!ifu_arready) next_cycle();
    next_cycle();
    ifu_arvalid = 1'b0;
    edges = 0;
    while (!ifu_rvalid) begin
      next_cycle();
      edges++;
    end
    check_equal("read data", expected, ifu_rdata);
    if (first) begin
      check_equal("first access to set", 1, mem_reads - reads0);
    end else begin
      check_equal("memory reads", hit ? 0 : 1, mem_reads - reads0);
    end
    if (hit) check_equal("hit latency", 1, edges);
    else check_equal("memory address", addr, mem_seen_addr);
    repeat (stall) begin
      next_cycle();
      check_equal("stalled rvalid", 1, ifu_rvalid);
      check_equal("stalled rdata", expected, ifu_rdata);
      check_equal("arready during stall", 0, ifu_arready);
    end
    ifu_rready = 1'b1;
    next_cycle();
    ifu_rready = 1'b0;
    check_equal("rvalid after transfer", 0, ifu_rvalid);
    check_equal("arready after transfer", 1, ifu_arready);
    check_equal("hit count", n_hit, hit_count);
    check_equal("miss count", n_miss, miss_count);
    check_equal("bypass count", n_bypass, bypass_count);
  endtask

  initial begin
    int slot;
    reset       = 1'b1;
    ifu_arvalid = 1'b0;
    ifu_araddr  = '0;
    ifu_rready  = 1'b0;
    ar_delay    = 0;
    r_delay     = 0;
    mem_reads   = 0;
    n_hit       = 0;
    n_miss      = 0;
    n_bypass    = 0;
    for (int i = 0; i < 8 * SETS; i++) tb_mem[i] = $random(seed);
    for (int s = 0; s < SETS; s++) m_valid[s] = 1'b0;
    repeat (RESET_CYC) @(posedge clock);
    #1;
    reset = 1'b0;
    for (int r = 0; r < NUM_REQ; r++) begin
      // stale lines in the cache must survive these rewrites.
      if ($unsigned($random(seed)) % 4 == 0) begin
        repeat (4) tb_mem[$unsigned($random(seed)) % (8 * SETS)] = $random(seed);
      end
      if ($unsigned($random(seed)) % 4 == 0) slot = $unsigned($random(seed)) % 2;
      else slot = 2 + $unsigned($random(seed)) % 6;
      run_request(slot_base(slot) | (($unsigned($random(seed)) % SETS) << `IC_M));
    end
    $display("errors: %0d, hits %0d, misses %0d, bypasses %0d", errors, n_hit, n_miss, n_bypass);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+src
src/icache_pkg.sv
src/icache_array.sv
src/icache_ctrl.sv
src/icache_perf.sv
src/icache_top.sv
tests/icache_props.sv
tests/icache_tb.sv
